//--- source/cc_offload_settings.svh
// --------------------------------------------------------------------------
// Widths, port counts, SSR geometry and buffer depths of the offload hub.
// Include this file wherever one of these macros is needed.
// --------------------------------------------------------------------------

`ifndef CC_OFFLOAD_SETTINGS_SVH
`define CC_OFFLOAD_SETTINGS_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define ID_WIDTH 5

// Offload ports: 0 FPU, 1 shared mul/div, 2 SSR config, 3 SNAX
`define ACC_SEL_WIDTH 2
`define NUM_ACC_PORTS 4
`define NUM_EXT_ACC 3
`define SSR_PORT_IDX 2

// SSR configuration space
`define NUM_SSRS 3
`define NUM_SSR_REGS 8

// TCDM window is 2**TCDM_ADDR_WIDTH bytes
`define TCDM_ADDR_WIDTH 17
`define DATA_RSP_DEPTH 4

`endif

//--- source/cc_offload_pkg.sv
// --------------------------------------------------------------------------
// Offload request and response types, the SSR operation word and the
// opcodes of the SSR configuration instructions.
// --------------------------------------------------------------------------

`include "cc_offload_settings.svh"

package cc_offload_pkg;

  typedef struct packed {
    logic [`ACC_SEL_WIDTH-1:0] port;
    logic [`ID_WIDTH-1:0]      id;
    logic [31:0]               op;
    logic [`DATA_WIDTH-1:0]    arga;
    logic [`DATA_WIDTH-1:0]    argb;
  } acc_req_t;

  typedef struct packed {
    logic [`ID_WIDTH-1:0]   id;
    logic [`DATA_WIDTH-1:0] data;
    logic                   error;
  } acc_rsp_t;

  // I-type layout, address lives in the immediate
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ssr_op_imm_t;

  // R-type layout, address comes in through a register
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } ssr_op_reg_t;

  typedef union packed {
    ssr_op_imm_t i;
    ssr_op_reg_t r;
  } ssr_op_u;

  // Custom-1 major opcode
  localparam logic [6:0] SSR_OP_CUSTOM = 7'b0101011;
  localparam logic [2:0] FUNCT3_SCFGRI = 3'b001;
  localparam logic [2:0] FUNCT3_SCFGWI = 3'b010;
  localparam logic [2:0] FUNCT3_SCFGR  = 3'b101;
  localparam logic [2:0] FUNCT3_SCFGW  = 3'b110;

endpackage

//--- source/offload_demux.sv
// --------------------------------------------------------------------------
// Offload request demux. Raises the valid of the accelerator port named by
// the port field of the request and returns that port's ready.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module offload_demux (
  input  cc_offload_pkg::acc_req_t        req_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  output logic [`NUM_ACC_PORTS-1:0]       valid_o,
  input  logic [`NUM_ACC_PORTS-1:0]       ready_i
);

  logic [`ACC_SEL_WIDTH-1:0] sel;

  assign sel = req_i.port;

  // One-hot valid, everything else low
  always_comb begin
    for (int k = 0; k < `NUM_ACC_PORTS; k++) begin
      valid_o[k] = valid_i && (sel == `ACC_SEL_WIDTH'(k));
    end
  end

  assign ready_o = ready_i[sel];

endmodule

//--- source/offload_rsp_arbiter.sv
// --------------------------------------------------------------------------
// Round-robin merge of the accelerator response streams into the single
// core response port. A stalled grant is locked until it transfers.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module offload_rsp_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  cc_offload_pkg::acc_rsp_t [`NUM_ACC_PORTS-1:0] rsp_i,
  input  logic [`NUM_ACC_PORTS-1:0]                     valid_i,
  output logic [`NUM_ACC_PORTS-1:0]                     ready_o,
  output cc_offload_pkg::acc_rsp_t                      rsp_o,
  output logic                                          valid_o,
  input  logic                                          ready_i
);

  localparam int IdxW = $clog2(`NUM_ACC_PORTS);

  logic [IdxW-1:0] prio_q;
  logic [IdxW-1:0] gnt_q;
  logic            lock_q;
  logic [IdxW-1:0] rr_sel;
  logic [IdxW-1:0] sel;
  logic            found;

  // First valid source at or after the priority pointer
  always_comb begin
    rr_sel = prio_q;
    found  = 1'b0;
    for (int i = 0; i < `NUM_ACC_PORTS; i++) begin
      if (!found && valid_i[IdxW'((int'(prio_q) + i) % `NUM_ACC_PORTS)]) begin
        rr_sel = IdxW'((int'(prio_q) + i) % `NUM_ACC_PORTS);
        found  = 1'b1;
      end
    end
  end

  assign sel     = lock_q ? gnt_q : rr_sel;
  assign valid_o = valid_i[sel];
  assign rsp_o   = rsp_i[sel];

  always_comb begin
    for (int k = 0; k < `NUM_ACC_PORTS; k++) begin
      ready_o[k] = ready_i && valid_o && (sel == IdxW'(k));
    end
  end

  // --------------------------------------------------------------------------
  // Grant lock and priority rotation
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      prio_q <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else if (valid_o) begin
      if (ready_i) begin
        lock_q <= 1'b0;
        prio_q <= (sel == IdxW'(`NUM_ACC_PORTS - 1)) ? '0 : sel + 1'b1;
      end else begin
        // Hold this source until the core takes it
        lock_q <= 1'b1;
        gnt_q  <= sel;
      end
    end
  end

endmodule

//--- source/ssr_cfg_regs.sv
// --------------------------------------------------------------------------
// SSR configuration endpoint on the offload bus. Decodes SCFGR/SCFGW in
// immediate and register form, holds the data mover registers and answers
// each request one cycle later from a single response slot.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module ssr_cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  cc_offload_pkg::acc_req_t req_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output cc_offload_pkg::acc_rsp_t rsp_o,
  output logic                     valid_o,
  input  logic                     ready_i
);

  import cc_offload_pkg::*;

  localparam int DmW  = $clog2(`NUM_SSRS);
  localparam int RegW = $clog2(`NUM_SSR_REGS);

  ssr_op_u                op;
  logic                   is_rdi;
  logic                   is_wri;
  logic                   is_rdr;
  logic                   is_wrr;
  logic                   is_write;
  logic [11:0]            addr;
  logic [4:0]             dm_sel;
  logic [6:0]             reg_sel;
  logic                   in_range;
  logic [`DATA_WIDTH-1:0] rdata;
  logic                   accept;

  logic [`DATA_WIDTH-1:0] regs_q [`NUM_SSRS][`NUM_SSR_REGS];
  acc_rsp_t               rsp_q;
  logic                   valid_q;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  assign op = req_i.op;

  assign is_rdi = (op.i.opcode == SSR_OP_CUSTOM) && (op.i.funct3 == FUNCT3_SCFGRI);
  assign is_wri = (op.i.opcode == SSR_OP_CUSTOM) && (op.i.funct3 == FUNCT3_SCFGWI);
  assign is_rdr = (op.r.opcode == SSR_OP_CUSTOM) && (op.r.funct7 == 7'd0)
               && (op.r.funct3 == FUNCT3_SCFGR);
  assign is_wrr = (op.r.opcode == SSR_OP_CUSTOM) && (op.r.funct7 == 7'd0)
               && (op.r.funct3 == FUNCT3_SCFGW);

  assign is_write = is_wri || is_wrr;

  // Register forms carry the address in argb
  assign addr = (is_rdi || is_wri) ? op.i.imm :
                (is_rdr || is_wrr) ? req_i.argb[11:0] : 12'd0;

  assign dm_sel  = addr[4:0];
  assign reg_sel = addr[11:5];

  assign in_range = (is_rdi || is_wri || is_rdr || is_wrr)
                 && (dm_sel < 5'(`NUM_SSRS)) && (reg_sel < 7'(`NUM_SSR_REGS));

  // Old value doubles as the write response
  assign rdata = in_range ? regs_q[dm_sel[DmW-1:0]][reg_sel[RegW-1:0]] : '0;

  // --------------------------------------------------------------------------
  // Registers and response slot
  // --------------------------------------------------------------------------
  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      valid_q <= 1'b0;
      for (int d = 0; d < `NUM_SSRS; d++) begin
        for (int r = 0; r < `NUM_SSR_REGS; r++) begin
          regs_q[d][r] <= '0;
        end
      end
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
      if (accept && is_write && in_range) begin
        regs_q[dm_sel[DmW-1:0]][reg_sel[RegW-1:0]] <= req_i.arga;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      // Id 0 keeps a write from writing back a register
      rsp_q.id    <= is_write ? '0 : req_i.id;
      rsp_q.data  <= rdata;
      rsp_q.error <= 1'b0;
    end
  end

  assign rsp_o   = rsp_q;
  assign valid_o = valid_q;

endmodule

//--- source/data_route.sv
// --------------------------------------------------------------------------
// Core data request router. Requests inside the NAPOT TCDM window go to the
// TCDM port, all others to the SoC port. Responses return in issue order.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module data_route (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`ADDR_WIDTH-1:0] base_i,
  input  logic [`ADDR_WIDTH-1:0] data_q_addr_i,
  input  logic                   data_q_write_i,
  input  logic [`DATA_WIDTH-1:0] data_q_wdata_i,
  input  logic                   data_q_valid_i,
  output logic                   data_q_ready_o,
  output logic [`DATA_WIDTH-1:0] data_p_rdata_o,
  output logic                   data_p_valid_o,
  input  logic                   data_p_ready_i,
  output logic [`ADDR_WIDTH-1:0] tcdm_q_addr_o,
  output logic                   tcdm_q_write_o,
  output logic [`DATA_WIDTH-1:0] tcdm_q_wdata_o,
  output logic                   tcdm_q_valid_o,
  input  logic                   tcdm_q_ready_i,
  input  logic [`DATA_WIDTH-1:0] tcdm_p_rdata_i,
  input  logic                   tcdm_p_valid_i,
  output logic                   tcdm_p_ready_o,
  output logic [`ADDR_WIDTH-1:0] soc_q_addr_o,
  output logic                   soc_q_write_o,
  output logic [`DATA_WIDTH-1:0] soc_q_wdata_o,
  output logic                   soc_q_valid_o,
  input  logic                   soc_q_ready_i,
  input  logic [`DATA_WIDTH-1:0] soc_p_rdata_i,
  input  logic                   soc_p_valid_i,
  output logic                   soc_p_ready_o
);

  localparam int CntW = $clog2(`DATA_RSP_DEPTH + 1);

  logic [`ADDR_WIDTH-1:0] mask;
  logic                   hit;
  logic                   stall;
  logic                   q_hs;
  logic                   p_hs;
  logic [CntW-1:0]        cnt_q;
  logic                   tgt_q;

  assign mask = {`ADDR_WIDTH{1'b1}} << `TCDM_ADDR_WIDTH;
  assign hit  = (data_q_addr_i & mask) == (base_i & mask);

  // Switching targets waits until the other side has drained
  assign stall = ((cnt_q != '0) && (tgt_q != hit)) || (cnt_q == CntW'(`DATA_RSP_DEPTH));

  assign tcdm_q_addr_o  = data_q_addr_i;
  assign tcdm_q_write_o = data_q_write_i;
  assign tcdm_q_wdata_o = data_q_wdata_i;
  assign tcdm_q_valid_o = data_q_valid_i && !stall && hit;
  assign soc_q_addr_o   = data_q_addr_i;
  assign soc_q_write_o  = data_q_write_i;
  assign soc_q_wdata_o  = data_q_wdata_i;
  assign soc_q_valid_o  = data_q_valid_i && !stall && !hit;

  assign data_q_ready_o = !stall && (hit ? tcdm_q_ready_i : soc_q_ready_i);

  // Responses only from the target of the outstanding requests
  assign data_p_valid_o = (cnt_q != '0) && (tgt_q ? tcdm_p_valid_i : soc_p_valid_i);
  assign data_p_rdata_o = tgt_q ? tcdm_p_rdata_i : soc_p_rdata_i;
  assign tcdm_p_ready_o = tgt_q && data_p_ready_i;
  assign soc_p_ready_o  = !tgt_q && data_p_ready_i;

  assign q_hs = data_q_valid_i && data_q_ready_o;
  assign p_hs = data_p_valid_o && data_p_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      cnt_q <= '0;
      tgt_q <= 1'b0;
    end else begin
      if (q_hs && !p_hs) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (p_hs && !q_hs) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (q_hs) begin
        tgt_q <= hit;
      end
    end
  end

endmodule

//--- source/snitch_offload_cc.sv
// --------------------------------------------------------------------------
// Offload hub of the core complex. Steers core offload requests to the
// external accelerators or the SSR config endpoint, merges their responses
// and routes core data requests to TCDM or SoC.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module snitch_offload_cc (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic [`ADDR_WIDTH-1:0]                      tcdm_base_i,
  input  cc_offload_pkg::acc_req_t                    acc_q_req_i,
  input  logic                                        acc_q_valid_i,
  output logic                                        acc_q_ready_o,
  output cc_offload_pkg::acc_rsp_t                    acc_p_rsp_o,
  output logic                                        acc_p_valid_o,
  input  logic                                        acc_p_ready_i,
  output cc_offload_pkg::acc_req_t                    ext_q_req_o,
  output logic [`NUM_EXT_ACC-1:0]                     ext_q_valid_o,
  input  logic [`NUM_EXT_ACC-1:0]                     ext_q_ready_i,
  input  cc_offload_pkg::acc_rsp_t [`NUM_EXT_ACC-1:0] ext_p_rsp_i,
  input  logic [`NUM_EXT_ACC-1:0]                     ext_p_valid_i,
  output logic [`NUM_EXT_ACC-1:0]                     ext_p_ready_o,
  input  logic [`ADDR_WIDTH-1:0]                      data_q_addr_i,
  input  logic                                        data_q_write_i,
  input  logic [`DATA_WIDTH-1:0]                      data_q_wdata_i,
  input  logic                                        data_q_valid_i,
  output logic                                        data_q_ready_o,
  output logic [`DATA_WIDTH-1:0]                      data_p_rdata_o,
  output logic                                        data_p_valid_o,
  input  logic                                        data_p_ready_i,
  output logic [`ADDR_WIDTH-1:0]                      tcdm_q_addr_o,
  output logic                                        tcdm_q_write_o,
  output logic [`DATA_WIDTH-1:0]                      tcdm_q_wdata_o,
  output logic                                        tcdm_q_valid_o,
  input  logic                                        tcdm_q_ready_i,
  input  logic [`DATA_WIDTH-1:0]                      tcdm_p_rdata_i,
  input  logic                                        tcdm_p_valid_i,
  output logic                                        tcdm_p_ready_o,
  output logic [`ADDR_WIDTH-1:0]                      soc_q_addr_o,
  output logic                                        soc_q_write_o,
  output logic [`DATA_WIDTH-1:0]                      soc_q_wdata_o,
  output logic                                        soc_q_valid_o,
  input  logic                                        soc_q_ready_i,
  input  logic [`DATA_WIDTH-1:0]                      soc_p_rdata_i,
  input  logic                                        soc_p_valid_i,
  output logic                                        soc_p_ready_o
);

  import cc_offload_pkg::*;

  logic [`NUM_ACC_PORTS-1:0]     lane_q_valid;
  logic [`NUM_ACC_PORTS-1:0]     lane_q_ready;
  acc_rsp_t [`NUM_ACC_PORTS-1:0] lane_p_rsp;
  logic [`NUM_ACC_PORTS-1:0]     lane_p_valid;
  logic [`NUM_ACC_PORTS-1:0]     lane_p_ready;

  acc_rsp_t ssr_p_rsp;
  logic     ssr_q_valid;
  logic     ssr_q_ready;
  logic     ssr_p_valid;
  logic     ssr_p_ready;

  // Request bus is shared, only the valids are steered
  assign ext_q_req_o = acc_q_req_i;

  // --------------------------------------------------------------------------
  // Offload lanes: SSR endpoint at its index, external ports fill the rest
  // --------------------------------------------------------------------------
  for (genvar k = 0; k < `NUM_ACC_PORTS; k++) begin : gen_lane
    if (k == `SSR_PORT_IDX) begin : gen_ssr
      assign ssr_q_valid     = lane_q_valid[k];
      assign lane_q_ready[k] = ssr_q_ready;
      assign lane_p_rsp[k]   = ssr_p_rsp;
      assign lane_p_valid[k] = ssr_p_valid;
      assign ssr_p_ready     = lane_p_ready[k];
    end else begin : gen_ext
      localparam int E = (k < `SSR_PORT_IDX) ? k : k - 1;
      assign ext_q_valid_o[E] = lane_q_valid[k];
      assign lane_q_ready[k]  = ext_q_ready_i[E];
      assign lane_p_rsp[k]    = ext_p_rsp_i[E];
      assign lane_p_valid[k]  = ext_p_valid_i[E];
      assign ext_p_ready_o[E] = lane_p_ready[k];
    end
  end

  offload_demux i_offload_demux (
    .req_i   (acc_q_req_i),
    .valid_i (acc_q_valid_i),
    .ready_o (acc_q_ready_o),
    .valid_o (lane_q_valid),
    .ready_i (lane_q_ready)
  );

  ssr_cfg_regs i_ssr_cfg_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (acc_q_req_i),
    .valid_i (ssr_q_valid),
    .ready_o (ssr_q_ready),
    .rsp_o   (ssr_p_rsp),
    .valid_o (ssr_p_valid),
    .ready_i (ssr_p_ready)
  );

  offload_rsp_arbiter i_offload_rsp_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rsp_i   (lane_p_rsp),
    .valid_i (lane_p_valid),
    .ready_o (lane_p_ready),
    .rsp_o   (acc_p_rsp_o),
    .valid_o (acc_p_valid_o),
    .ready_i (acc_p_ready_i)
  );

  data_route i_data_route (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .base_i         (tcdm_base_i),
    .data_q_addr_i  (data_q_addr_i),
    .data_q_write_i (data_q_write_i),
    .data_q_wdata_i (data_q_wdata_i),
    .data_q_valid_i (data_q_valid_i),
    .data_q_ready_o (data_q_ready_o),
    .data_p_rdata_o (data_p_rdata_o),
    .data_p_valid_o (data_p_valid_o),
    .data_p_ready_i (data_p_ready_i),
    .tcdm_q_addr_o  (tcdm_q_addr_o),
    .tcdm_q_write_o (tcdm_q_write_o),
    .tcdm_q_wdata_o (tcdm_q_wdata_o),
    .tcdm_q_valid_o (tcdm_q_valid_o),
    .tcdm_q_ready_i (tcdm_q_ready_i),
    .tcdm_p_rdata_i (tcdm_p_rdata_i),
    .tcdm_p_valid_i (tcdm_p_valid_i),
    .tcdm_p_ready_o (tcdm_p_ready_o),
    .soc_q_addr_o   (soc_q_addr_o),
    .soc_q_write_o  (soc_q_write_o),
    .soc_q_wdata_o  (soc_q_wdata_o),
    .soc_q_valid_o  (soc_q_valid_o),
    .soc_q_ready_i  (soc_q_ready_i),
    .soc_p_rdata_i  (soc_p_rdata_i),
    .soc_p_valid_i  (soc_p_valid_i),
    .soc_p_ready_o  (soc_p_ready_o)
  );

endmodule

//--- tb/snitch_offload_cc_assertions.sv
// --------------------------------------------------------------------------
// Protocol checks for the offload hub, bound to the top level. Covers reset
// quiet outputs, response stability, demux steering and data depth.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module snitch_offload_cc_assertions (
  input logic                           clk_i,
  input logic                           rst_ni,
  input cc_offload_pkg::acc_req_t       acc_q_req_i,
  input logic                           acc_q_valid_i,
  input cc_offload_pkg::acc_rsp_t       acc_p_rsp_o,
  input logic                           acc_p_valid_o,
  input logic                           acc_p_ready_i,
  input logic [`NUM_EXT_ACC-1:0]        ext_q_valid_o,
  input logic                           data_q_valid_i,
  input logic                           data_q_ready_o,
  input logic                           data_p_valid_o,
  input logic                           data_p_ready_i,
  input logic                           tcdm_q_valid_o,
  input logic                           soc_q_valid_o
);

  import cc_offload_pkg::*;

  logic [3:0] outstanding;
  logic       fail_seen = 1'b0;

  // Own count of data requests in flight
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(data_q_valid_i && data_q_ready_o)
                                 - 4'(data_p_valid_o && data_p_ready_i);
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) $past(rst_ni) |->
    !(acc_p_valid_o || (|ext_q_valid_o) || data_p_valid_o || tcdm_q_valid_o || soc_q_valid_o))
    else begin
      fail_seen = 1'b1;
      $error("Valid output high during or right after reset");
    end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_p_valid_o && !acc_p_ready_i |=> acc_p_valid_o && $stable(acc_p_rsp_o))
    else begin
      fail_seen = 1'b1;
      $error("Core response changed while stalled");
    end

  a_ssr_quiet: assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_q_valid_i && (acc_q_req_i.port == `ACC_SEL_WIDTH'(`SSR_PORT_IDX)) |-> ext_q_valid_o == '0)
    else begin
      fail_seen = 1'b1;
      $error("SSR request leaked to an external port");
    end

  a_data_depth: assert property (@(posedge clk_i) disable iff (rst_ni)
    outstanding <= 4'(`DATA_RSP_DEPTH))
    else begin
      fail_seen = 1'b1;
      $error("Too many outstanding data requests");
    end

endmodule

bind snitch_offload_cc snitch_offload_cc_assertions i_assertions (.*);

//--- tb/tb_snitch_offload_cc.sv
// --------------------------------------------------------------------------
// Testbench for the offload hub. Random offload and data traffic against
// random-latency responders, checked against queue-based reference models.
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "cc_offload_settings.svh"

module tb_snitch_offload_cc;

  import cc_offload_pkg::*;

  localparam int NumReq = 150;
  localparam int MaxCycles = 2000;
  localparam logic [31:0] TcdmBase = 32'h1000_0000;

  logic clk_i = 1'b0;
  logic rst_ni, acc_q_valid_i, acc_q_ready_o, acc_p_valid_o, acc_p_ready_i;
  acc_req_t acc_q_req_i, ext_q_req_o;
  acc_rsp_t acc_p_rsp_o;
  acc_rsp_t [2:0] ext_p_rsp_i;
  logic [2:0] ext_q_valid_o, ext_q_ready_i, ext_p_valid_i, ext_p_ready_o;
  logic [31:0] data_q_addr_i, data_q_wdata_i, data_p_rdata_o;
  logic data_q_write_i, data_q_valid_i, data_q_ready_o, data_p_valid_o, data_p_ready_i;
  logic [31:0] tcdm_q_addr_o, tcdm_q_wdata_o, tcdm_p_rdata_i;
  logic [31:0] soc_q_addr_o, soc_q_wdata_o, soc_p_rdata_i;
  logic tcdm_q_write_o, tcdm_q_valid_o, tcdm_q_ready_i, tcdm_p_valid_i, tcdm_p_ready_o;
  logic soc_q_write_o, soc_q_valid_o, soc_q_ready_i, soc_p_valid_i, soc_p_ready_o;

  // Reference state
  acc_rsp_t    ext_pend [3][$];
  acc_rsp_t    ssr_exp[$];
  logic [31:0] ssr_model [3][8];
  logic [31:0] tcdm_pend[$], soc_pend[$], data_exp[$];
  logic [2:0]  ext_taken = '0;
  logic        tcdm_taken = 1'b0, soc_taken = 1'b0;
  int          cycles = 0;

  snitch_offload_cc DUT (.*, .tcdm_base_i(TcdmBase));

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic mismatch(input string msg);
    $display("Mismatch at %0d ns: %s", $time, msg);
    stop_on_error();
  endtask

  // Expected SSR answer decoded from the instruction format
  task automatic model_ssr(input acc_req_t req);
    logic [2:0]  f3;
    logic [11:0] addr;
    logic        wr;
    logic        inr;
    acc_rsp_t    rsp;
    f3   = req.op[14:12];
    wr   = (f3 == FUNCT3_SCFGWI) || (f3 == FUNCT3_SCFGW);
    addr = (f3 == FUNCT3_SCFGRI || f3 == FUNCT3_SCFGWI) ? req.op[31:20] : req.argb[11:0];
    inr  = (addr[4:0] < 5'd3) && (addr[11:5] < 7'd8);
    rsp.id    = wr ? '0 : req.id;
    rsp.data  = inr ? ssr_model[addr[1:0]][addr[7:5]] : '0;
    rsp.error = 1'b0;
    ssr_exp.push_back(rsp);
    if (wr && inr) begin
      ssr_model[addr[1:0]][addr[7:5]] = req.arga;
    end
  endtask

  task automatic drive_offload();
    acc_req_t    req;
    logic [2:0]  f3;
    logic [11:0] addr;
    for (int i = 0; i < NumReq; i++) begin
      req.port = 2'($urandom_range(3));
      req.id   = 5'($urandom);
      req.op   = $urandom;
      req.arga = $urandom;
      req.argb = $urandom;
      if (req.port == 2'(`SSR_PORT_IDX)) begin
        case ($urandom_range(3))
          0: f3 = FUNCT3_SCFGRI;
          1: f3 = FUNCT3_SCFGWI;
          2: f3 = FUNCT3_SCFGR;
          default: f3 = FUNCT3_SCFGW;
        endcase
        // Small address space so reads hit earlier writes, some out of range
        addr = {7'($urandom_range(8)), 5'($urandom_range(3))};
        if ($urandom_range(9) == 0) addr = 12'($urandom);
        if (f3 == FUNCT3_SCFGRI || f3 == FUNCT3_SCFGWI) begin
          req.op = {addr, 5'($urandom), f3, 5'($urandom), SSR_OP_CUSTOM};
        end else begin
          req.op   = {7'd0, 5'($urandom), 5'($urandom), f3, 5'($urandom), SSR_OP_CUSTOM};
          req.argb = {req.argb[31:12], addr};
        end
      end
      acc_q_req_i   = req;
      acc_q_valid_i = 1'b1;
      @(negedge clk_i);
      while (!acc_q_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1 acc_q_valid_i = 1'b0;
    end
  endtask

  task automatic drive_data();
    for (int i = 0; i < NumReq; i++) begin
      data_q_addr_i  = TcdmBase | 32'($urandom_range(32'h1_ffff));
      if ($urandom_range(1) == 0) data_q_addr_i = $urandom | 32'h0010_0000;
      data_q_write_i = 1'($urandom);
      data_q_wdata_i = $urandom;
      data_q_valid_i = 1'b1;
      @(negedge clk_i);
      while (!data_q_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1 data_q_valid_i = 1'b0;
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks sampled mid-cycle where every input is settled
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic     ext_hs;
    logic     hit;
    acc_rsp_t rsp;
    int       ext_idx;
    if (DUT.i_assertions.fail_seen) begin
      $display("A bound protocol assertion failed");
      stop_on_error();
    end
    if (!rst_ni) begin
      ext_hs = 1'b0;
      for (int e = 0; e < 3; e++) begin
        if (ext_q_valid_o[e] && ext_q_ready_i[e]) begin
          rsp.id    = acc_q_req_i.id;
          rsp.data  = $urandom;
          rsp.error = 1'($urandom);
          ext_pend[e].push_back(rsp);
        end
        if (ext_p_valid_i[e] && ext_p_ready_o[e]) begin
          ext_hs = 1'b1;
          assert (acc_p_valid_o && acc_p_ready_i && acc_p_rsp_o == ext_p_rsp_i[e])
            else mismatch("external response not forwarded intact");
          void'(ext_pend[e].pop_front());
          ext_taken[e] = 1'b1;
        end
      end
      if (acc_p_valid_o && acc_p_ready_i && !ext_hs) begin
        assert (ssr_exp.size() > 0) else mismatch("core response with no source");
        rsp = ssr_exp.pop_front();
        assert (acc_p_rsp_o == rsp) else mismatch("SSR response id or data wrong");
      end
      if (acc_q_valid_i && acc_q_req_i.port != 2'(`SSR_PORT_IDX)) begin
        ext_idx = (acc_q_req_i.port == 2'd3) ? 2 : int'(acc_q_req_i.port);
        assert (ext_q_req_o == acc_q_req_i && ext_q_valid_o == 3'(1 << ext_idx)
                && acc_q_ready_o == ext_q_ready_i[ext_idx])
          else mismatch("offload request steered to the wrong port");
      end
      if (acc_q_valid_i && acc_q_ready_o && acc_q_req_i.port == 2'(`SSR_PORT_IDX)) begin
        model_ssr(acc_q_req_i);
      end
      if (data_q_valid_i && data_q_ready_o) begin
        hit = ((data_q_addr_i ^ TcdmBase) >> `TCDM_ADDR_WIDTH) == 0;
        assert (tcdm_q_valid_o == hit && soc_q_valid_o == !hit
                && (hit ? tcdm_q_addr_o : soc_q_addr_o) == data_q_addr_i
                && (hit ? tcdm_q_write_o : soc_q_write_o) == data_q_write_i
                && (hit ? tcdm_q_wdata_o : soc_q_wdata_o) == data_q_wdata_i)
          else mismatch("data request sent to the wrong memory port");
        data_exp.push_back($urandom);
        if (hit) tcdm_pend.push_back(data_exp[$]);
        else soc_pend.push_back(data_exp[$]);
      end
      if (tcdm_p_valid_i && tcdm_p_ready_o) begin
        void'(tcdm_pend.pop_front());
        tcdm_taken = 1'b1;
      end
      if (soc_p_valid_i && soc_p_ready_o) begin
        void'(soc_pend.pop_front());
        soc_taken = 1'b1;
      end
      if (data_p_valid_o && data_p_ready_i) begin
        assert (data_exp.size() > 0 && data_p_rdata_o == data_exp.pop_front())
          else mismatch("read data out of issue order");
      end
    end
  end

  // Responders with random ready and random response delay
  always @(posedge clk_i) begin
    #1;
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles with traffic still pending", cycles);
      stop_on_error();
    end
    if (!rst_ni) begin
      acc_p_ready_i  = ($urandom_range(3) != 0);
      data_p_ready_i = ($urandom_range(3) != 0);
      tcdm_q_ready_i = ($urandom_range(3) != 0);
      soc_q_ready_i  = ($urandom_range(3) != 0);
      for (int e = 0; e < 3; e++) begin
        ext_q_ready_i[e] = ($urandom_range(3) != 0);
        if (!ext_p_valid_i[e] || ext_taken[e]) begin
          ext_p_valid_i[e] = (ext_pend[e].size() > 0) && ($urandom_range(2) != 0);
          if (ext_p_valid_i[e]) ext_p_rsp_i[e] = ext_pend[e][0];
        end
      end
      if (!tcdm_p_valid_i || tcdm_taken) begin
        tcdm_p_valid_i = (tcdm_pend.size() > 0) && ($urandom_range(2) != 0);
        if (tcdm_p_valid_i) tcdm_p_rdata_i = tcdm_pend[0];
      end
      if (!soc_p_valid_i || soc_taken) begin
        soc_p_valid_i = (soc_pend.size() > 0) && ($urandom_range(3) == 0);
        if (soc_p_valid_i) soc_p_rdata_i = soc_pend[0];
      end
      ext_taken  = '0;
      tcdm_taken = 1'b0;
      soc_taken  = 1'b0;
    end
  end

  initial begin
    void'($urandom(32'h6695_376e));
    rst_ni = 1'b1;
    {acc_q_valid_i, acc_p_ready_i, data_q_valid_i, data_q_write_i, data_p_ready_i} = '0;
    {tcdm_q_ready_i, tcdm_p_valid_i, soc_q_ready_i, soc_p_valid_i} = '0;
    {ext_q_ready_i, ext_p_valid_i} = '0;
    acc_q_req_i = '0;
    ext_p_rsp_i = '0;
    {data_q_addr_i, data_q_wdata_i, tcdm_p_rdata_i, soc_p_rdata_i} = '0;
    foreach (ssr_model[d, r]) ssr_model[d][r] = '0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    fork
      drive_offload();
      drive_data();
    join
    // Drain every outstanding response
    while (ext_pend[0].size() + ext_pend[1].size() + ext_pend[2].size()
           + ssr_exp.size() + data_exp.size() > 0) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    if (DUT.i_assertions.fail_seen) begin
      stop_on_error();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- snitch_offload_cc.f
+incdir+source
source/cc_offload_pkg.sv
source/offload_demux.sv
source/offload_rsp_arbiter.sv
source/ssr_cfg_regs.sv
source/data_route.sv
source/snitch_offload_cc.sv
tb/snitch_offload_cc_assertions.sv
tb/tb_snitch_offload_cc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the offload hub testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f snitch_offload_cc.f \
  --top-module tb_snitch_offload_cc -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "^Done: no errors$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
